//--- logic/tinkerIsaPkg.sv
package tinkerIsaPkg;

    localparam int wordWidth     = 64;  // Register and data width
    localparam int instWidth     = 32;
    localparam int regIndexWidth = 5;
    localparam int literalWidth  = 12;

    typedef enum logic [4:0] {
        opAnd      = 5'h00,
        opOr       = 5'h01,
        opXor      = 5'h02,
        opNot      = 5'h03,
        opShftr    = 5'h04,
        opShftri   = 5'h05,
        opShftl    = 5'h06,
        opShftli   = 5'h07,
        opBr       = 5'h08,
        opBrr      = 5'h09,
        opBrri     = 5'h0A,
        opBrnz     = 5'h0B,
        opBrgt     = 5'h0E,
        opPriv     = 5'h0F,  // Halt
        opMovLoad  = 5'h10,
        opMovReg   = 5'h11,
        opMovLit   = 5'h12,
        opMovStore = 5'h13,
        opAdd      = 5'h18,
        opAddi     = 5'h19,
        opSub      = 5'h1A,
        opSubi     = 5'h1B,
        opMul      = 5'h1C,
        opDiv      = 5'h1D
    } opcode_e;

    // Three register fields
    typedef struct packed {
        opcode_e                  opcode;
        logic [regIndexWidth-1:0] rd;
        logic [regIndexWidth-1:0] rs;
        logic [regIndexWidth-1:0] rt;
        logic [literalWidth-1:0]  unused;
    } regForm_t;

    // Literal in the low bits, rt position unused
    typedef struct packed {
        opcode_e                                                    opcode;
        logic [regIndexWidth-1:0]                                   rd;
        logic [regIndexWidth-1:0]                                   rs;
        logic [instWidth-$bits(opcode_e)-2*regIndexWidth-literalWidth-1:0] pad;
        logic [literalWidth-1:0]                                    literal;
    } litForm_t;

    typedef union packed {
        regForm_t regForm;
        litForm_t litForm;
    } instWord_u;

endpackage

//--- logic/tinkerCorePkg.sv
package tinkerCorePkg;

    localparam logic [tinkerIsaPkg::wordWidth-1:0] resetPc  = 64'h2000;
    localparam logic [tinkerIsaPkg::wordWidth-1:0] stackTop = 64'd524288;  // Register 31
    localparam int instBytes = 4;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        HALTED
    } stage_e;

    // One enable per stage, at most one set
    typedef struct packed {
        logic fetch;
        logic decode;
        logic execute;
        logic memory;
        logic writeback;
    } stageEnables_t;

    typedef struct packed {
        tinkerIsaPkg::opcode_e                      opcode;
        logic [tinkerIsaPkg::regIndexWidth-1:0]     rd;
        logic [tinkerIsaPkg::wordWidth-1:0]         operandA;
        logic [tinkerIsaPkg::wordWidth-1:0]         operandB;  // rt or literal
        logic [tinkerIsaPkg::wordWidth-1:0]         rdValue;
        logic [tinkerIsaPkg::wordWidth-1:0]         pc;
    } decoded_t;

    typedef struct packed {
        logic [tinkerIsaPkg::wordWidth-1:0] addr;
        logic [tinkerIsaPkg::wordWidth-1:0] wdata;
        logic                               read;
        logic                               write;
    } dataReq_t;

    typedef struct packed {
        logic [tinkerIsaPkg::wordWidth-1:0]     result;
        logic [tinkerIsaPkg::wordWidth-1:0]     nextPc;
        dataReq_t                               dataReq;
        logic                                   writeReg;
        logic                                   needsMemory;
        logic                                   isLoad;
        logic                                   halt;
        logic [tinkerIsaPkg::regIndexWidth-1:0] rd;
    } execResult_t;

endpackage

//--- logic/registerFile.sv
`timescale 1ns/10ps

module registerFile (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [tinkerIsaPkg::regIndexWidth-1:0] readIndexA,
    input  logic [tinkerIsaPkg::regIndexWidth-1:0] readIndexB,
    input  logic [tinkerIsaPkg::regIndexWidth-1:0] readIndexD,
    input  logic                                   writeEnable,
    input  logic [tinkerIsaPkg::regIndexWidth-1:0] writeIndex,
    input  logic [tinkerIsaPkg::wordWidth-1:0]     writeData,
    output logic [tinkerIsaPkg::wordWidth-1:0]     valueA,
    output logic [tinkerIsaPkg::wordWidth-1:0]     valueB,
    output logic [tinkerIsaPkg::wordWidth-1:0]     valueD
);
    logic [tinkerIsaPkg::wordWidth-1:0] regs [2**tinkerIsaPkg::regIndexWidth];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < $size(regs); i++) begin
                // Top register is the stack pointer
                regs[i] <= (i == $size(regs) - 1) ? tinkerCorePkg::stackTop : '0;
            end
        end else if (writeEnable) begin
            regs[writeIndex] <= writeData;
        end
    end

    assign valueA = regs[readIndexA];
    assign valueB = regs[readIndexB];
    assign valueD = regs[readIndexD];

endmodule

//--- logic/stageSequencer.sv
`timescale 1ns/10ps

module stageSequencer (
    input  logic                         clk,
    input  logic                         reset,
    input  tinkerCorePkg::execResult_t   execResult,
    output tinkerCorePkg::stageEnables_t stageEnables,
    output logic                         hlt
);
    tinkerCorePkg::stage_e stage;
    tinkerCorePkg::stage_e nextStage;

    always_comb begin
        nextStage = stage;
        case (stage)
            tinkerCorePkg::FETCH:  nextStage = tinkerCorePkg::DECODE;
            tinkerCorePkg::DECODE: nextStage = tinkerCorePkg::EXECUTE;
            tinkerCorePkg::EXECUTE: begin
                if (execResult.halt) nextStage = tinkerCorePkg::HALTED;
                else if (execResult.needsMemory) nextStage = tinkerCorePkg::MEMORY;
                else if (execResult.writeReg) nextStage = tinkerCorePkg::WRITEBACK;
                else nextStage = tinkerCorePkg::FETCH;  // Branches
            end
            tinkerCorePkg::MEMORY: begin
                if (execResult.isLoad) nextStage = tinkerCorePkg::WRITEBACK;
                else nextStage = tinkerCorePkg::FETCH;
            end
            tinkerCorePkg::WRITEBACK: nextStage = tinkerCorePkg::FETCH;
            default: nextStage = stage;  // HALTED holds until reset
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stage <= tinkerCorePkg::FETCH;
        end else begin
            stage <= nextStage;
        end
    end

    assign stageEnables.fetch     = (stage == tinkerCorePkg::FETCH);
    assign stageEnables.decode    = (stage == tinkerCorePkg::DECODE);
    assign stageEnables.execute   = (stage == tinkerCorePkg::EXECUTE);
    assign stageEnables.memory    = (stage == tinkerCorePkg::MEMORY);
    assign stageEnables.writeback = (stage == tinkerCorePkg::WRITEBACK);
    assign hlt = (stage == tinkerCorePkg::HALTED);

    // WRITEBACK only for instructions that write a register
    assert property (@(posedge clk) disable iff (reset)
        stageEnables.writeback |-> execResult.writeReg);

endmodule

//--- logic/fetchStage.sv
`timescale 1ns/10ps

module fetchStage (
    input  logic                               clk,
    input  logic                               reset,
    input  tinkerCorePkg::stageEnables_t       stageEnables,
    input  logic [tinkerIsaPkg::wordWidth-1:0] nextPc,
    output logic [tinkerIsaPkg::wordWidth-1:0] pc,
    output logic                               instReq,
    output logic [tinkerIsaPkg::wordWidth-1:0] instAddr
);
    // nextPc holds the previous instruction's successor, resetPc after reset
    assign instAddr = nextPc;
    assign instReq  = stageEnables.fetch;

    // PC of the instruction in flight
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= tinkerCorePkg::resetPc;
        end else if (stageEnables.fetch) begin
            pc <= nextPc;
        end
    end

endmodule

//--- logic/decodeStage.sv
`timescale 1ns/10ps

module decodeStage (
    input  logic                                   clk,
    input  logic                                   reset,
    input  tinkerCorePkg::stageEnables_t           stageEnables,
    input  tinkerIsaPkg::instWord_u                instWord,
    input  logic [tinkerIsaPkg::wordWidth-1:0]     pc,
    input  logic                                   writeEnable,
    input  logic [tinkerIsaPkg::regIndexWidth-1:0] writeIndex,
    input  logic [tinkerIsaPkg::wordWidth-1:0]     writeData,
    output tinkerCorePkg::decoded_t                decoded
);
    tinkerIsaPkg::opcode_e                  opcode;
    logic                                   usesLiteral;
    logic                                   readsRd;
    logic [tinkerIsaPkg::regIndexWidth-1:0] indexA;
    logic [tinkerIsaPkg::wordWidth-1:0]     valueA;
    logic [tinkerIsaPkg::wordWidth-1:0]     valueB;
    logic [tinkerIsaPkg::wordWidth-1:0]     valueD;
    logic [tinkerIsaPkg::wordWidth-1:0]     literalValue;

    assign opcode = instWord.regForm.opcode;

    always_comb begin
        usesLiteral = 1'b0;
        readsRd     = 1'b0;
        case (opcode)
            // Immediate forms work on rd itself
            tinkerIsaPkg::opAddi, tinkerIsaPkg::opSubi, tinkerIsaPkg::opShftri,
            tinkerIsaPkg::opShftli, tinkerIsaPkg::opMovLit: begin
                usesLiteral = 1'b1;
                readsRd     = 1'b1;
            end
            tinkerIsaPkg::opBrri, tinkerIsaPkg::opMovLoad, tinkerIsaPkg::opMovStore:
                usesLiteral = 1'b1;
            default: ;
        endcase
    end

    assign indexA = readsRd ? instWord.litForm.rd : instWord.regForm.rs;
    assign literalValue = {{(tinkerIsaPkg::wordWidth - tinkerIsaPkg::literalWidth){1'b0}},
                           instWord.litForm.literal};

    registerFile registerFile_i (
        .clk         (clk),
        .reset       (reset),
        .readIndexA  (indexA),
        .readIndexB  (instWord.regForm.rt),
        .readIndexD  (instWord.regForm.rd),
        .writeEnable (writeEnable),
        .writeIndex  (writeIndex),
        .writeData   (writeData),
        .valueA      (valueA),
        .valueB      (valueB),
        .valueD      (valueD)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            decoded <= '0;
        end else if (stageEnables.decode) begin
            decoded.opcode   <= opcode;
            decoded.rd       <= instWord.regForm.rd;
            decoded.operandA <= valueA;
            decoded.operandB <= usesLiteral ? literalValue : valueB;
            decoded.rdValue  <= valueD;
            decoded.pc       <= pc;
        end
    end

endmodule

//--- logic/executeStage.sv
`timescale 1ns/10ps

module executeStage (
    input  logic                         clk,
    input  logic                         reset,
    input  tinkerCorePkg::stageEnables_t stageEnables,
    input  tinkerCorePkg::decoded_t      decoded,
    output tinkerCorePkg::execResult_t   result
);
    logic [tinkerIsaPkg::wordWidth-1:0] a;
    logic [tinkerIsaPkg::wordWidth-1:0] b;
    logic [tinkerIsaPkg::wordWidth-1:0] branchOffset;
    logic [tinkerIsaPkg::wordWidth-1:0] aluValue;
    logic [tinkerIsaPkg::wordWidth-1:0] pcTarget;
    logic [tinkerIsaPkg::wordWidth-1:0] resultReg;
    logic [tinkerIsaPkg::wordWidth-1:0] nextPcReg;
    tinkerCorePkg::dataReq_t            dataReqNext;
    tinkerCorePkg::dataReq_t            dataReqReg;
    logic                               writeReg;
    logic                               needsMemory;
    logic                               isLoad;
    logic                               halt;

    assign a = decoded.operandA;
    assign b = decoded.operandB;
    // brri literal is signed so loops can jump back
    assign branchOffset = {{(tinkerIsaPkg::wordWidth - tinkerIsaPkg::literalWidth)
                            {b[tinkerIsaPkg::literalWidth-1]}},
                           b[tinkerIsaPkg::literalWidth-1:0]};

    always_comb begin
        aluValue    = '0;
        pcTarget    = decoded.pc + 64'(tinkerCorePkg::instBytes);
        dataReqNext = '0;
        case (decoded.opcode)
            tinkerIsaPkg::opAdd, tinkerIsaPkg::opAddi: aluValue = a + b;
            tinkerIsaPkg::opSub, tinkerIsaPkg::opSubi: aluValue = a - b;
            tinkerIsaPkg::opMul: aluValue = a * b;
            tinkerIsaPkg::opDiv: aluValue = (b == '0) ? '1 : a / b;  // x/0 gives all ones
            tinkerIsaPkg::opAnd: aluValue = a & b;
            tinkerIsaPkg::opOr:  aluValue = a | b;
            tinkerIsaPkg::opXor: aluValue = a ^ b;
            tinkerIsaPkg::opNot: aluValue = ~a;
            tinkerIsaPkg::opShftr, tinkerIsaPkg::opShftri: aluValue = a >> b;
            tinkerIsaPkg::opShftl, tinkerIsaPkg::opShftli: aluValue = a << b;
            tinkerIsaPkg::opMovReg: aluValue = a;
            tinkerIsaPkg::opMovLit: aluValue = {a[63:12], b[11:0]};  // Low bits only
            tinkerIsaPkg::opMovLoad: begin
                dataReqNext.addr = a + b;
                dataReqNext.read = 1'b1;
            end
            tinkerIsaPkg::opMovStore: begin
                dataReqNext.addr  = decoded.rdValue + b;
                dataReqNext.wdata = a;
                dataReqNext.write = 1'b1;
            end
            tinkerIsaPkg::opBr:   pcTarget = decoded.rdValue;
            tinkerIsaPkg::opBrr:  pcTarget = decoded.pc + decoded.rdValue;
            tinkerIsaPkg::opBrri: pcTarget = decoded.pc + branchOffset;
            tinkerIsaPkg::opBrnz: if (a != '0) pcTarget = decoded.rdValue;
            tinkerIsaPkg::opBrgt: if (a > b) pcTarget = decoded.rdValue;  // Unsigned
            default: ;
        endcase
    end

    // Path flags follow the held decode word, so they are valid during EXECUTE
    always_comb begin
        writeReg    = 1'b1;
        needsMemory = 1'b0;
        isLoad      = 1'b0;
        halt        = 1'b0;
        case (decoded.opcode)
            tinkerIsaPkg::opMovLoad: begin
                needsMemory = 1'b1;
                isLoad      = 1'b1;
            end
            tinkerIsaPkg::opMovStore: begin
                needsMemory = 1'b1;
                writeReg    = 1'b0;
            end
            tinkerIsaPkg::opBr, tinkerIsaPkg::opBrr, tinkerIsaPkg::opBrri,
            tinkerIsaPkg::opBrnz, tinkerIsaPkg::opBrgt:
                writeReg = 1'b0;
            tinkerIsaPkg::opPriv: begin
                halt     = 1'b1;
                writeReg = 1'b0;
            end
            default: ;
        endcase
    end

    // nextPc starts at resetPc so the first fetch needs no special case
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            nextPcReg  <= tinkerCorePkg::resetPc;
            dataReqReg <= '0;
        end else if (stageEnables.execute) begin
            nextPcReg  <= pcTarget;
            dataReqReg <= dataReqNext;
        end
    end

    always_ff @(posedge clk) begin
        if (stageEnables.execute) begin
            resultReg <= aluValue;
        end
    end

    always_comb begin
        result.result      = resultReg;
        result.nextPc      = nextPcReg;
        result.dataReq     = dataReqReg;
        result.writeReg    = writeReg;
        result.needsMemory = needsMemory;
        result.isLoad      = isLoad;
        result.halt        = halt;
        result.rd          = decoded.rd;
    end

    // A MEMORY cycle carries exactly one strobe
    assert property (@(posedge clk) disable iff (reset)
        stageEnables.memory |-> (dataReqReg.read != dataReqReg.write));

endmodule

//--- logic/writebackStage.sv
`timescale 1ns/10ps

module writebackStage (
    input  tinkerCorePkg::stageEnables_t           stageEnables,
    input  tinkerCorePkg::execResult_t             execResult,
    input  logic [tinkerIsaPkg::wordWidth-1:0]     dataRdata,
    output tinkerCorePkg::dataReq_t                dataRequest,
    output logic                                   writeEnable,
    output logic [tinkerIsaPkg::regIndexWidth-1:0] writeIndex,
    output logic [tinkerIsaPkg::wordWidth-1:0]     writeData
);
    // Strobes reach the port only in MEMORY
    always_comb begin
        dataRequest       = execResult.dataReq;
        dataRequest.read  = execResult.dataReq.read && stageEnables.memory;
        dataRequest.write = execResult.dataReq.write && stageEnables.memory;
    end

    assign writeEnable = stageEnables.writeback && execResult.writeReg;
    assign writeIndex  = execResult.rd;
    assign writeData   = execResult.isLoad ? dataRdata : execResult.result;  // Load data arrives now

    // Load data is taken only after a read request
    always_comb begin
        assert (!(writeEnable && execResult.isLoad) || execResult.dataReq.read);
    end

endmodule

//--- logic/tinkerCore.sv
`timescale 1ns/10ps

module tinkerCore (
    input  logic                               clk,
    input  logic                               reset,
    output logic                               instReq,
    output logic [tinkerIsaPkg::wordWidth-1:0] instAddr,
    input  tinkerIsaPkg::instWord_u            instWord,
    output tinkerCorePkg::dataReq_t            dataRequest,
    input  logic [tinkerIsaPkg::wordWidth-1:0] dataRdata,
    output logic                               hlt
);
    tinkerCorePkg::stageEnables_t           stageEnables;
    tinkerCorePkg::decoded_t                decoded;
    tinkerCorePkg::execResult_t             execResult;
    logic [tinkerIsaPkg::wordWidth-1:0]     pc;
    logic                                   writeEnable;
    logic [tinkerIsaPkg::regIndexWidth-1:0] writeIndex;
    logic [tinkerIsaPkg::wordWidth-1:0]     writeData;

    stageSequencer stageSequencer_i (
        .clk          (clk),
        .reset        (reset),
        .execResult   (execResult),
        .stageEnables (stageEnables),
        .hlt          (hlt)
    );

    fetchStage fetchStage_i (
        .clk          (clk),
        .reset        (reset),
        .stageEnables (stageEnables),
        .nextPc       (execResult.nextPc),
        .pc           (pc),
        .instReq      (instReq),
        .instAddr     (instAddr)
    );

    decodeStage decodeStage_i (
        .clk          (clk),
        .reset        (reset),
        .stageEnables (stageEnables),
        .instWord     (instWord),
        .pc           (pc),
        .writeEnable  (writeEnable),
        .writeIndex   (writeIndex),
        .writeData    (writeData),
        .decoded      (decoded)
    );

    executeStage executeStage_i (
        .clk          (clk),
        .reset        (reset),
        .stageEnables (stageEnables),
        .decoded      (decoded),
        .result       (execResult)
    );

    writebackStage writebackStage_i (
        .stageEnables (stageEnables),
        .execResult   (execResult),
        .dataRdata    (dataRdata),
        .dataRequest  (dataRequest),
        .writeEnable  (writeEnable),
        .writeIndex   (writeIndex),
        .writeData    (writeData)
    );

endmodule

//--- dv/tinkerCoreTb.sv
`timescale 1ns/10ps

module tinkerCoreTb;

    typedef struct packed {
        logic [11:0][31:0] code;        // Instruction words from 0x2000 on
        logic [3:0]        instCount;
        logic [3:0][63:0]  presetAddr;
        logic [3:0][63:0]  presetData;
        logic [2:0]        presetCount;
        logic [7:0][63:0]  storeAddr;   // Expected store log
        logic [7:0][63:0]  storeData;
        logic [3:0]        storeCount;
        logic [7:0]        execCount;   // Instructions executed, loops unrolled
    } testEntry_t;

    logic                    clk = 1'b0;
    logic                    reset = 1'b1;
    logic                    instReq;
    logic [63:0]             instAddr;
    tinkerIsaPkg::instWord_u instWord = '0;
    tinkerCorePkg::dataReq_t dataRequest;
    logic [63:0]             dataRdata = '0;
    logic                    hlt;

    testEntry_t  tests [$];
    string       testNames [$];
    testEntry_t  entry;
    string       entryName;
    testEntry_t  current;
    logic [63:0] dataMem [logic [63:0]];
    logic [63:0] storeAddrLog [$];
    logic [63:0] storeDataLog [$];
    logic        instPending = 1'b0;
    logic [63:0] pendingInstAddr = '0;
    logic        readPending = 1'b0;
    logic [63:0] pendingReadAddr = '0;
    logic        afterHalt = 1'b0;
    int          cycleCount = 0;
    int          timeoutLimit = 0;
    logic [31:0] rngState = 32'h36dc_df92;

    tinkerCore tinkerCore_i (
        .clk         (clk),
        .reset       (reset),
        .instReq     (instReq),
        .instAddr    (instAddr),
        .instWord    (instWord),
        .dataRequest (dataRequest),
        .dataRdata   (dataRdata),
        .hlt         (hlt)
    );

    always #10 clk = ~clk;

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic checkValue(input string testName, input string what,
                              input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            failRun($sformatf("error: %s %s expected %h actual %h",
                              testName, what, expected, actual));
        end
    endtask

    function automatic logic [31:0] encode(input tinkerIsaPkg::opcode_e op, input int rd,
                                           input int rs, input int rt, input int lit);
        return {op, rd[4:0], rs[4:0], rt[4:0], lit[11:0]};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [63:0] randomWord();
        logic [31:0] high;
        rngState = xorshift(rngState);
        high = rngState;
        rngState = xorshift(rngState);
        return {high, rngState};
    endfunction

    // Outside the program the memory answers with priv
    function automatic logic [31:0] fetchWord(input logic [63:0] addr);
        int index;
        index = int'((addr - tinkerCorePkg::resetPc) >> 2);
        if (addr >= tinkerCorePkg::resetPc && index < 12) begin
            return current.code[index[3:0]];
        end
        return encode(tinkerIsaPkg::opPriv, 0, 0, 0, 0);
    endfunction

    function automatic logic [63:0] readData(input logic [63:0] addr);
        if (dataMem.exists(addr)) begin
            return dataMem[addr];
        end
        return addr ^ 64'hDEAD_BEEF_0BAD_F00D;  // Unset words
    endfunction

    task automatic startEntry(input string name, input int execCount);
        entry = '0;
        entryName = name;
        entry.execCount = execCount[7:0];
        for (int i = 0; i < 12; i++) begin
            entry.code[i[3:0]] = encode(tinkerIsaPkg::opPriv, 0, 0, 0, 0);
        end
    endtask

    task automatic putInst(input tinkerIsaPkg::opcode_e op, input int rd, input int rs,
                           input int rt, input int lit);
        entry.code[entry.instCount] = encode(op, rd, rs, rt, lit);
        entry.instCount = entry.instCount + 4'd1;
    endtask

    task automatic loadFrom(input int rd, input int lit);
        putInst(tinkerIsaPkg::opMovLoad, rd, 0, 0, lit);
    endtask

    task automatic storeTo(input int lit, input int rs);
        putInst(tinkerIsaPkg::opMovStore, 0, rs, 0, lit);
    endtask

    task automatic presetWord(input logic [63:0] addr, input logic [63:0] data);
        entry.presetAddr[entry.presetCount[1:0]] = addr;
        entry.presetData[entry.presetCount[1:0]] = data;
        entry.presetCount = entry.presetCount + 3'd1;
    endtask

    task automatic expectStore(input logic [63:0] addr, input logic [63:0] data);
        entry.storeAddr[entry.storeCount[2:0]] = addr;
        entry.storeData[entry.storeCount[2:0]] = data;
        entry.storeCount = entry.storeCount + 4'd1;
    endtask

    task automatic commitEntry();
        tests.push_back(entry);
        testNames.push_back(entryName);
    endtask

    // Operands from 0x100 and 0x108, results r3 to r6 stored from 0x200
    task automatic fourOpTest(input string name, input logic [63:0] a, input logic [63:0] b,
                              input tinkerIsaPkg::opcode_e op0, input tinkerIsaPkg::opcode_e op1,
                              input tinkerIsaPkg::opcode_e op2, input tinkerIsaPkg::opcode_e op3,
                              input logic [63:0] e0, input logic [63:0] e1,
                              input logic [63:0] e2, input logic [63:0] e3);
        startEntry(name, 11);
        presetWord(64'h100, a);
        presetWord(64'h108, b);
        loadFrom(1, 12'h100);
        loadFrom(2, 12'h108);
        putInst(op0, 3, 1, 2, 0);
        putInst(op1, 4, 1, 2, 0);
        putInst(op2, 5, 1, 2, 0);
        putInst(op3, 6, 1, 2, 0);
        storeTo(12'h200, 3);
        storeTo(12'h208, 4);
        storeTo(12'h210, 5);
        storeTo(12'h218, 6);
        expectStore(64'h200, e0);
        expectStore(64'h208, e1);
        expectStore(64'h210, e2);
        expectStore(64'h218, e3);
        commitEntry();
    endtask

    task automatic buildTable();
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] v;
        logic [63:0] e1;
        logic [63:0] e2;
        logic [63:0] e3;
        a = 64'h0123_4567_89AB_CDEF;
        b = 64'h0000_0000_0001_2345;
        fourOpTest("arith", a, b, tinkerIsaPkg::opAdd, tinkerIsaPkg::opSub,
                   tinkerIsaPkg::opMul, tinkerIsaPkg::opDiv, a + b, a - b, a * b, a / b);
        fourOpTest("logic", a, b, tinkerIsaPkg::opAnd, tinkerIsaPkg::opOr,
                   tinkerIsaPkg::opXor, tinkerIsaPkg::opNot, a & b, a | b, a ^ b, ~a);

        v = 64'h0000_1234_5678_9ABC;
        e1 = v + 64'h123;
        e2 = (e1 - 64'h45) >> 4;
        e3 = ((e2 << 8) & ~64'hFFF) | 64'hABC;  // mov literal keeps the upper bits
        startEntry("immediate", 12);
        presetWord(64'h100, v);
        loadFrom(1, 12'h100);
        putInst(tinkerIsaPkg::opAddi, 1, 0, 0, 12'h123);
        storeTo(12'h200, 1);
        putInst(tinkerIsaPkg::opSubi, 1, 0, 0, 12'h045);
        putInst(tinkerIsaPkg::opShftri, 1, 0, 0, 4);
        storeTo(12'h208, 1);
        putInst(tinkerIsaPkg::opShftli, 1, 0, 0, 8);
        putInst(tinkerIsaPkg::opMovLit, 1, 0, 0, 12'hABC);
        storeTo(12'h210, 1);
        putInst(tinkerIsaPkg::opMovReg, 2, 1, 0, 0);
        storeTo(12'h218, 2);
        expectStore(64'h200, e1);
        expectStore(64'h208, e2);
        expectStore(64'h210, e3);
        expectStore(64'h218, e3);
        commitEntry();

        v = 64'h8000_0000_F00D_0001;
        startEntry("shiftReg", 9);
        presetWord(64'h100, v);
        presetWord(64'h108, 64'd13);
        loadFrom(1, 12'h100);
        loadFrom(2, 12'h108);
        putInst(tinkerIsaPkg::opShftr, 3, 1, 2, 0);
        putInst(tinkerIsaPkg::opShftl, 4, 1, 2, 0);
        putInst(tinkerIsaPkg::opDiv, 5, 1, 0, 0);  // r0 is zero
        storeTo(12'h200, 3);
        storeTo(12'h208, 4);
        storeTo(12'h210, 5);
        expectStore(64'h200, v >> 13);
        expectStore(64'h208, v << 13);
        expectStore(64'h210, 64'hFFFF_FFFF_FFFF_FFFF);
        commitEntry();

        v = 64'h5555_AAAA_1234_8765;
        startEntry("loadStore", 5);
        presetWord(64'h410, v);
        putInst(tinkerIsaPkg::opMovLit, 2, 0, 0, 12'h400);
        putInst(tinkerIsaPkg::opMovLoad, 3, 2, 0, 12'h010);
        putInst(tinkerIsaPkg::opMovStore, 2, 3, 0, 12'h020);
        putInst(tinkerIsaPkg::opMovStore, 2, 31, 0, 12'h028);  // Stack pointer after reset
        expectStore(64'h420, v);
        expectStore(64'h428, 64'd524288);
        commitEntry();

        startEntry("brnzLoop", 14);
        putInst(tinkerIsaPkg::opMovLit, 1, 0, 0, 3);
        putInst(tinkerIsaPkg::opMovLit, 2, 0, 0, 2);
        putInst(tinkerIsaPkg::opShftli, 2, 0, 0, 12);
        putInst(tinkerIsaPkg::opAddi, 2, 0, 0, 12'h010);     // Loop head at 0x2010
        putInst(tinkerIsaPkg::opMovStore, 1, 1, 0, 12'h200);
        putInst(tinkerIsaPkg::opSubi, 1, 0, 0, 1);
        putInst(tinkerIsaPkg::opBrnz, 2, 1, 0, 0);
        expectStore(64'h203, 64'd3);
        expectStore(64'h202, 64'd2);
        expectStore(64'h201, 64'd1);
        commitEntry();

        startEntry("brgtUnsigned", 11);
        putInst(tinkerIsaPkg::opMovLit, 1, 0, 0, 5);
        putInst(tinkerIsaPkg::opNot, 3, 1, 0, 0);           // Negative if read as signed
        putInst(tinkerIsaPkg::opMovLit, 2, 0, 0, 2);
        putInst(tinkerIsaPkg::opShftli, 2, 0, 0, 12);
        putInst(tinkerIsaPkg::opMovReg, 4, 2, 0, 0);
        putInst(tinkerIsaPkg::opAddi, 2, 0, 0, 12'h024);
        putInst(tinkerIsaPkg::opAddi, 4, 0, 0, 12'h02C);
        putInst(tinkerIsaPkg::opBrgt, 2, 3, 1, 0);          // Taken
        storeTo(12'h200, 1);
        putInst(tinkerIsaPkg::opBrgt, 4, 1, 3, 0);          // Not taken
        storeTo(12'h208, 3);
        expectStore(64'h208, ~64'd5);
        commitEntry();

        startEntry("jumps", 10);
        putInst(tinkerIsaPkg::opMovLit, 1, 0, 0, 2);
        putInst(tinkerIsaPkg::opShftli, 1, 0, 0, 12);
        putInst(tinkerIsaPkg::opAddi, 1, 0, 0, 12'h014);
        putInst(tinkerIsaPkg::opBr, 1, 0, 0, 0);
        storeTo(12'h200, 1);
        putInst(tinkerIsaPkg::opMovLit, 2, 0, 0, 12'h00C);
        putInst(tinkerIsaPkg::opBrr, 2, 0, 0, 0);
        storeTo(12'h210, 2);                                // Reached from the backward brri
        putInst(tinkerIsaPkg::opPriv, 0, 0, 0, 0);
        putInst(tinkerIsaPkg::opBrri, 0, 0, 0, 8);
        storeTo(12'h218, 2);
        putInst(tinkerIsaPkg::opBrri, 0, 0, 0, -16);
        expectStore(64'h210, 64'h00C);
        commitEntry();

        startEntry("halt", 2);
        storeTo(12'h200, 31);
        putInst(tinkerIsaPkg::opPriv, 0, 0, 0, 0);
        storeTo(12'h208, 31);
        expectStore(64'h200, 64'd524288);
        commitEntry();

        for (int i = 0; i < 8; i++) begin
            a = randomWord();
            b = randomWord();
            fourOpTest($sformatf("random%0d", i), a, b, tinkerIsaPkg::opAdd,
                       tinkerIsaPkg::opSub, tinkerIsaPkg::opXor, tinkerIsaPkg::opMul,
                       a + b, a - b, a ^ b, a * b);
        end
    endtask

    task automatic runTest(input testEntry_t test, input string name);
        int waited;
        @(negedge clk);
        reset = 1'b1;
        afterHalt = 1'b0;
        current = test;
        dataMem.delete();
        storeAddrLog.delete();
        storeDataLog.delete();
        for (int i = 0; i < int'(test.presetCount); i++) begin
            dataMem[test.presetAddr[i[1:0]]] = test.presetData[i[1:0]];
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        checkValue(name, "hlt after reset", 64'(1'b0), 64'(hlt));
        checkValue(name, "instReq after reset", 64'(1'b1), 64'(instReq));
        checkValue(name, "fetch address after reset", 64'h2000, instAddr);
        checkValue(name, "data strobes after reset", 64'd0,
                   64'({dataRequest.read, dataRequest.write}));

        waited = 0;
        while (!hlt) begin
            @(negedge clk);
            waited++;
            if (waited > 5 * int'(test.execCount) + 10) begin
                failRun($sformatf("%s: hlt did not rise within %0d cycles", name, waited));
            end
        end
        afterHalt = 1'b1;  // Memory model now flags any request
        repeat (6) @(negedge clk);
        checkValue(name, "hlt held", 64'(1'b1), 64'(hlt));
        afterHalt = 1'b0;

        checkValue(name, "store count", 64'(test.storeCount), 64'(storeAddrLog.size()));
        for (int i = 0; i < storeAddrLog.size(); i++) begin
            checkValue(name, $sformatf("store %0d address", i), test.storeAddr[i[2:0]],
                       storeAddrLog[i]);
            checkValue(name, $sformatf("store %0d data", i), test.storeData[i[2:0]],
                       storeDataLog[i]);
        end
    endtask

    // Both memories answer one cycle after the request
    always @(negedge clk) begin
        if (instPending) begin
            instWord = fetchWord(pendingInstAddr);
        end
        instPending = instReq;
        pendingInstAddr = instAddr;
        if (readPending) begin
            dataRdata = readData(pendingReadAddr);
        end
        readPending = dataRequest.read;
        pendingReadAddr = dataRequest.addr;
        if (dataRequest.write) begin
            storeAddrLog.push_back(dataRequest.addr);
            storeDataLog.push_back(dataRequest.wdata);
            dataMem[dataRequest.addr] = dataRequest.wdata;
        end
        if (afterHalt && (instReq || dataRequest.read || dataRequest.write)) begin
            failRun("memory request seen while the core is halted");
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (timeoutLimit > 0 && cycleCount > timeoutLimit) begin
            failRun($sformatf("timeout: run exceeded %0d cycles", timeoutLimit));
        end
    end

    initial begin
        buildTable();
        foreach (tests[t]) begin
            timeoutLimit += 5 * int'(tests[t].execCount) + 20;
        end
        for (int t = 0; t < tests.size(); t++) begin
            runTest(tests[t], testNames[t]);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- files.f
logic/tinkerIsaPkg.sv
logic/tinkerCorePkg.sv
logic/registerFile.sv
logic/stageSequencer.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/writebackStage.sv
logic/tinkerCore.sv
dv/tinkerCoreTb.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tinkerCoreTb -f files.f -o tinkerCoreSim \
    && ./obj_dir/tinkerCoreSim | tee sim.log
grep -q "PASS: all tests" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
